//--- testbench/dcache_input.txt
# op: L load, S store, F flush, E enable, D disable
# op address data be expected_miss (hex)
E 00000000 00000000 0 0
L 00000040 00000000 0 1
L 00000048 00000000 0 0
L 0000004c 00000000 0 0
S 00000044 a5a5a5a5 f 0
L 00000044 00000000 0 0
S 00000048 11223344 3 0
L 00000048 00000000 0 0
S 00000230 deadbeef f 0
L 00000230 00000000 0 1
S 00000534 cafef00d 6 0
L 00000534 00000000 0 1
L 00000538 00000000 0 0
L 00000040 00000000 0 0
F 00000000 00000000 0 0
L 00000040 00000000 0 1
L 00000534 00000000 0 1
L 00000230 00000000 0 1
D 00000000 00000000 0 0
L 00000040 00000000 0 1
L 00000040 00000000 0 1
S 00000040 0badf00d 9 0
L 00000044 00000000 0 1
E 00000000 00000000 0 0
L 00000044 00000000 0 0
L 00000040 00000000 0 0
L 00000680 00000000 0 1
L 00000780 00000000 0 1
L 00000684 00000000 0 1
L 00000788 00000000 0 1
L 0000068c 00000000 0 1
F 00000000 00000000 0 0
L 0000068c 00000000 0 1

//--- all.f
hw/dcache_pkg.sv
hw/dcache_mem.sv
hw/dcache_load_ctrl.sv
hw/dcache_store_ctrl.sv
hw/dcache_miss_unit.sv
hw/wt_dcache.sv
testbench/tb_clk_gen.sv
testbench/tb_wt_dcache.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the write-through dcache testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  -f all.f \
  --top-module tb_wt_dcache \
  -o tb_wt_dcache

./obj_dir/tb_wt_dcache | tee sim.log

if grep -qx 'All tests passed!' sim.log; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed"
  exit 1
fi

//--- testbench/tb_wt_dcache.sv
//////////////////////////////////////////////////
// testbench for the write-through dcache
// replays the operation list against a memory
// model and checks loads, stores and flushes
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_wt_dcache
  import dcache_pkg::*;
();

  localparam int mem_words = 1024;

  logic                  clk_i;
  logic                  rst_i;
  logic                  enable_i;
  logic                  flush_i;
  logic                  flush_ack_o;
  logic                  miss_o;
  logic                  ld_req_i;
  logic [addr_width-1:0] ld_addr_i;
  logic                  ld_ready_o;
  logic                  ld_valid_o;
  logic [xlen-1:0]       ld_data_o;
  logic                  st_req_i;
  logic [addr_width-1:0] st_addr_i;
  logic [xlen-1:0]       st_data_i;
  logic [xlen/8-1:0]     st_be_i;
  logic                  st_ready_o;
  logic                  mem_req_o;
  mem_kind_t             mem_kind_o;
  logic [addr_width-1:0] mem_addr_o;
  logic [xlen-1:0]       mem_wdata_o;
  logic [xlen/8-1:0]     mem_be_o;
  logic                  mem_ack_i;
  logic                  mem_rtrn_vld_i;
  logic [line_width-1:0] mem_rtrn_data_i;

  // memory model contents and the expected view of memory
  logic [31:0] ref_mem [mem_words];
  logic [31:0] exp_mem [mem_words];

  // operation list
  logic [7:0]  op_list   [$];
  logic [31:0] addr_list [$];
  logic [31:0] data_list [$];
  logic [31:0] be_list   [$];
  logic [31:0] miss_list [$];

  int unsigned n_errors;
  int unsigned n_refill;
  int unsigned n_read_nc;
  int unsigned n_write;
  int unsigned n_miss;
  int unsigned n_valid;
  int unsigned n_flush_ack;
  int unsigned cycle_limit;
  logic [31:0] rd_addr_seen;
  logic [31:0] wr_addr_seen;
  logic [31:0] wr_data_seen;
  logic [3:0]  wr_be_seen;
  logic        cache_on;

  tb_clk_gen i_clk_gen (
    .clk_o (clk_i),
    .rst_o (rst_i)
  );

  wt_dcache i_dut (.*);

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("mismatch %s: got %h expected %h", name, got, exp);
    n_errors++;
  endtask

  //////////////////////////////////////////////////
  // memory model
  //////////////////////////////////////////////////

  initial begin : mem_model
    logic [31:0] rnd;
    logic [1:0]  phase;
    logic [1:0]  delay;
    mem_kind_t   kind;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  be;
    rnd             = 32'hfbb305db;
    phase           = 2'd0;
    delay           = 2'd0;
    kind            = mem_refill;
    addr            = '0;
    wdata           = '0;
    be              = '0;
    mem_ack_i       = 1'b0;
    mem_rtrn_vld_i  = 1'b0;
    mem_rtrn_data_i = '0;
    for (int i = 0; i < mem_words; i++) begin
      rnd        = xorshift32(rnd);
      ref_mem[i] = rnd;
      exp_mem[i] = rnd;
    end
    forever begin
      @(negedge clk_i);
      mem_ack_i      = 1'b0;
      mem_rtrn_vld_i = 1'b0;
      if (rst_i) begin
        phase = 2'd0;
      end else if (phase == 2'd0) begin
        if (mem_req_o) begin
          kind  = mem_kind_o;
          addr  = mem_addr_o;
          wdata = mem_wdata_o;
          be    = mem_be_o;
          rnd   = xorshift32(rnd);
          delay = rnd[1:0];
          phase = 2'd1;
          if (addr[31:12] != '0) begin
            $display("memory request outside the modelled range at %h", addr);
            n_errors++;
          end
          if (kind == mem_refill) begin
            n_refill++;
            rd_addr_seen = addr;
          end else if (kind == mem_read_nc) begin
            n_read_nc++;
            rd_addr_seen = addr;
          end else begin
            n_write++;
            wr_addr_seen = addr;
            wr_data_seen = wdata;
            wr_be_seen   = be;
          end
        end
      end else if (phase == 2'd1) begin
        if (!mem_req_o) begin
          $display("memory request dropped before its acknowledge");
          n_errors++;
        end
        if (delay == 2'd0) begin
          mem_ack_i = 1'b1;
          if (kind == mem_write) begin
            for (int b = 0; b < 4; b++) begin
              if (be[b]) ref_mem[addr[11:2]][b*8 +: 8] = wdata[b*8 +: 8];
            end
            phase = 2'd0;
          end else begin
            rnd   = xorshift32(rnd);
            delay = rnd[1:0];
            phase = 2'd2;
          end
        end else begin
          delay = delay - 2'd1;
        end
      end else begin
        if (delay == 2'd0) begin
          mem_rtrn_vld_i  = 1'b1;
          mem_rtrn_data_i = '0;
          if (kind == mem_refill) begin
            for (int w = 0; w < line_words; w++) begin
              mem_rtrn_data_i[w*xlen +: xlen] = ref_mem[int'(addr[11:4]) * 4 + w];
            end
          end else begin
            mem_rtrn_data_i[xlen-1:0] = ref_mem[addr[11:2]];
          end
          phase = 2'd0;
        end else begin
          delay = delay - 2'd1;
        end
      end
    end
  end

  // count pulses on the falling edge
  initial begin : pulse_monitor
    n_miss      = 0;
    n_valid     = 0;
    n_flush_ack = 0;
    forever begin
      @(negedge clk_i);
      if (!rst_i) begin
        if (miss_o) n_miss++;
        if (ld_valid_o) n_valid++;
        if (flush_ack_o) n_flush_ack++;
      end
    end
  end

  initial begin : watchdog
    int unsigned cycles;
    cycles = 0;
    while (cycle_limit == 0 || cycles <= cycle_limit) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("run stopped after %0d cycles without finishing, %0d errors", cycles,
             n_errors);
    $display("Test failures found");
    $finish;
  end

  //////////////////////////////////////////////////
  // operations
  //////////////////////////////////////////////////

  task automatic run_load(input logic [31:0] addr, input logic exp_miss);
    int unsigned miss0;
    int unsigned valid0;
    int unsigned refill0;
    int unsigned nc0;
    int unsigned write0;
    logic [31:0] got;
    while (!ld_ready_o) @(negedge clk_i);
    miss0     = n_miss;
    valid0    = n_valid;
    refill0   = n_refill;
    nc0       = n_read_nc;
    write0    = n_write;
    ld_req_i  = 1'b1;
    ld_addr_i = addr;
    @(negedge clk_i);
    ld_req_i = 1'b0;
    while (!ld_valid_o) @(negedge clk_i);
    got = ld_data_o;
    @(negedge clk_i);
    if (got !== exp_mem[addr[11:2]]) report_mismatch("ld_data_o", got, exp_mem[addr[11:2]]);
    if (n_miss - miss0 != 32'(exp_miss)) report_mismatch("miss_o pulses", n_miss - miss0,
                                                         32'(exp_miss));
    // a miss reads the line when enabled, a single word otherwise
    if (n_refill - refill0 != 32'(exp_miss && cache_on)) begin
      report_mismatch("refill reads", n_refill - refill0, 32'(exp_miss && cache_on));
    end
    if (n_read_nc - nc0 != 32'(exp_miss && !cache_on)) begin
      report_mismatch("single-word reads", n_read_nc - nc0, 32'(exp_miss && !cache_on));
    end
    if (n_refill != refill0 && rd_addr_seen !== {addr[31:4], 4'h0}) begin
      report_mismatch("mem_addr_o", rd_addr_seen, {addr[31:4], 4'h0});
    end
    if (n_read_nc != nc0 && rd_addr_seen !== {addr[31:2], 2'b00}) begin
      report_mismatch("mem_addr_o", rd_addr_seen, {addr[31:2], 2'b00});
    end
    if (n_write != write0) report_mismatch("memory writes", n_write - write0, 32'd0);
    if (n_valid - valid0 != 1) report_mismatch("ld_valid_o pulses", n_valid - valid0, 32'd1);
  endtask

  task automatic run_store(input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] be);
    int unsigned write0;
    int unsigned read0;
    int unsigned miss0;
    while (!st_ready_o) @(negedge clk_i);
    write0    = n_write;
    read0     = n_refill + n_read_nc;
    miss0     = n_miss;
    st_req_i  = 1'b1;
    st_addr_i = addr;
    st_data_i = data;
    st_be_i   = be;
    @(negedge clk_i);
    st_req_i = 1'b0;
    while (!st_ready_o) @(negedge clk_i);
    @(negedge clk_i);
    if (n_write - write0 != 1) report_mismatch("memory writes", n_write - write0, 32'd1);
    if (wr_addr_seen !== {addr[31:2], 2'b00}) begin
      report_mismatch("mem_addr_o", wr_addr_seen, {addr[31:2], 2'b00});
    end
    if (wr_data_seen !== data) report_mismatch("mem_wdata_o", wr_data_seen, data);
    if (wr_be_seen !== be) report_mismatch("mem_be_o", 32'(wr_be_seen), 32'(be));
    if (n_refill + n_read_nc != read0) begin
      report_mismatch("memory reads", n_refill + n_read_nc - read0, 32'd0);
    end
    if (n_miss != miss0) report_mismatch("miss_o pulses", n_miss - miss0, 32'd0);
    for (int b = 0; b < 4; b++) begin
      if (be[b]) exp_mem[addr[11:2]][b*8 +: 8] = data[b*8 +: 8];
    end
  endtask

  task automatic run_flush();
    int unsigned ack0;
    int unsigned req0;
    while (!(ld_ready_o && st_ready_o)) @(negedge clk_i);
    ack0    = n_flush_ack;
    req0    = n_refill + n_read_nc + n_write;
    flush_i = 1'b1;
    @(negedge clk_i);
    while (!flush_ack_o) @(negedge clk_i);
    flush_i = 1'b0;
    @(negedge clk_i);
    if (n_flush_ack - ack0 != 1) report_mismatch("flush_ack_o pulses", n_flush_ack - ack0,
                                                 32'd1);
    if (n_refill + n_read_nc + n_write != req0) begin
      report_mismatch("memory requests", n_refill + n_read_nc + n_write - req0, 32'd0);
    end
  endtask

  initial begin : stimulus
    int    fd;
    int    n_fields;
    string line;
    string rest;
    logic [31:0] a;
    logic [31:0] d;
    logic [31:0] b;
    logic [31:0] m;
    n_errors    = 0;
    n_refill    = 0;
    n_read_nc   = 0;
    n_write     = 0;
    cycle_limit = 0;
    cache_on    = 1'b1;
    enable_i    = 1'b1;
    flush_i     = 1'b0;
    ld_req_i    = 1'b0;
    ld_addr_i   = '0;
    st_req_i    = 1'b0;
    st_addr_i   = '0;
    st_data_i   = '0;
    st_be_i     = '0;
    fd = $fopen("testbench/dcache_input.txt", "r");
    if (fd == 0) begin
      $display("could not open the operation list");
      n_errors++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() > 1 && line.getc(0) != "#") begin
          rest     = line.substr(1, line.len() - 1);
          n_fields = $sscanf(rest, "%h %h %h %h", a, d, b, m);
          if (n_fields != 4) begin
            $display("malformed line in the operation list: %s", line);
            n_errors++;
          end else begin
            op_list.push_back(line.getc(0));
            addr_list.push_back(a);
            data_list.push_back(d);
            be_list.push_back(b);
            miss_list.push_back(m);
          end
        end
      end
      $fclose(fd);
    end
    cycle_limit = op_list.size() * 40 + 200;
    while (rst_i) @(posedge clk_i);
    @(negedge clk_i);
    for (int k = 0; k < op_list.size(); k++) begin
      case (op_list[k])
        "L": run_load(addr_list[k], miss_list[k][0]);
        "S": run_store(addr_list[k], data_list[k], be_list[k][3:0]);
        "F": run_flush();
        "E", "D": begin
          cache_on = (op_list[k] == "E");
          enable_i = cache_on;
          @(negedge clk_i);
        end
        default: begin
          $display("unknown operation %c in the operation list", op_list[k]);
          n_errors++;
        end
      endcase
    end
    $display("%0d operations run, %0d errors", op_list.size(), n_errors);
    if (n_errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- testbench/tb_clk_gen.sv
//////////////////////////////////////////////////
// testbench clock and reset
// 8 ns clock, reset held for two cycles
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
  output logic clk_o,
  output logic rst_o
);

  initial begin
    clk_o = 1'b0;
    forever #4 clk_o = ~clk_o;
  end

  // release on a falling edge, away from the sampling edge
  initial begin
    rst_o = 1'b1;
    repeat (2) @(posedge clk_o);
    @(negedge clk_o);
    rst_o = 1'b0;
  end

endmodule

`default_nettype wire

//--- hw/wt_dcache.sv
//////////////////////////////////////////////////
// write-through L1 data cache
// direct mapped, one load and one store port,
// single outstanding memory transaction
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module wt_dcache
  import dcache_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_i,
  // cache management
  input  logic                  enable_i,
  input  logic                  flush_i,
  output logic                  flush_ack_o,
  output logic                  miss_o,
  // load port
  input  logic                  ld_req_i,
  input  dcache_addr_t          ld_addr_i,
  output logic                  ld_ready_o,
  output logic                  ld_valid_o,
  output logic [xlen-1:0]       ld_data_o,
  // store port
  input  logic                  st_req_i,
  input  dcache_addr_t          st_addr_i,
  input  logic [xlen-1:0]       st_data_i,
  input  logic [xlen/8-1:0]     st_be_i,
  output logic                  st_ready_o,
  // memory
  output logic                  mem_req_o,
  output mem_kind_t             mem_kind_o,
  output logic [addr_width-1:0] mem_addr_o,
  output logic [xlen-1:0]       mem_wdata_o,
  output logic [xlen/8-1:0]     mem_be_o,
  input  logic                  mem_ack_i,
  input  logic                  mem_rtrn_vld_i,
  input  logic [line_width-1:0] mem_rtrn_data_i
);

  logic cache_en;

  // load controller <-> arrays
  logic                 ld_rd_req;
  logic [idx_width-1:0] ld_rd_idx;
  logic [off_width-1:0] ld_rd_off;
  logic                 ld_rd_ack;
  logic [tag_width-1:0] rd_tag;
  logic                 rd_valid;
  logic [xlen-1:0]      rd_data;

  // store controller <-> arrays
  logic              st_wr_req;
  dcache_addr_t      st_wr_addr;
  logic [xlen-1:0]   st_wr_data;
  logic [xlen/8-1:0] st_wr_be;
  logic              st_wr_ack;

  // miss unit <-> arrays
  logic                  fill_vld;
  logic [idx_width-1:0]  fill_idx;
  logic [tag_width-1:0]  fill_tag;
  logic [line_width-1:0] fill_data;
  logic                  inval_vld;
  logic [idx_width-1:0]  inval_idx;

  // controllers <-> miss unit
  logic              lmiss_req;
  logic              lmiss_nc;
  dcache_addr_t      lmiss_addr;
  logic              lmiss_done;
  logic [xlen-1:0]   lmiss_word;
  logic              smiss_req;
  dcache_addr_t      smiss_addr;
  logic [xlen-1:0]   smiss_data;
  logic [xlen/8-1:0] smiss_be;
  logic              smiss_ack;

  // hit result is consumed inside the arrays
  dcache_mem i_dcache_mem (
    .st_wr_hit (),
    .*
  );

  dcache_load_ctrl i_dcache_load_ctrl (.*);

  dcache_store_ctrl i_dcache_store_ctrl (.*);

  dcache_miss_unit i_dcache_miss_unit (
    .ld_busy (!ld_ready_o),
    .st_busy (!st_ready_o),
    .*
  );

endmodule

`default_nettype wire

//--- hw/dcache_miss_unit.sv
//////////////////////////////////////////////////
// dcache miss unit
// memory port arbiter, refill sequencer and the
// flush walk over all line indices
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module dcache_miss_unit
  import dcache_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  enable_i,
  input  logic                  flush_i,
  output logic                  flush_ack_o,
  output logic                  cache_en,
  // load miss port
  input  logic                  lmiss_req,
  input  logic                  lmiss_nc,
  input  dcache_addr_t          lmiss_addr,
  output logic                  lmiss_done,
  output logic [xlen-1:0]       lmiss_word,
  // store write-through port
  input  logic                  smiss_req,
  input  dcache_addr_t          smiss_addr,
  input  logic [xlen-1:0]       smiss_data,
  input  logic [xlen/8-1:0]     smiss_be,
  output logic                  smiss_ack,
  // arrays
  output logic                  fill_vld,
  output logic [idx_width-1:0]  fill_idx,
  output logic [tag_width-1:0]  fill_tag,
  output logic [line_width-1:0] fill_data,
  output logic                  inval_vld,
  output logic [idx_width-1:0]  inval_idx,
  input  logic                  ld_busy,
  input  logic                  st_busy,
  // memory
  output logic                  mem_req_o,
  output mem_kind_t             mem_kind_o,
  output logic [addr_width-1:0] mem_addr_o,
  output logic [xlen-1:0]       mem_wdata_o,
  output logic [xlen/8-1:0]     mem_be_o,
  input  logic                  mem_ack_i,
  input  logic                  mem_rtrn_vld_i,
  input  logic [line_width-1:0] mem_rtrn_data_i
);

  localparam logic [2:0] s_idle      = 3'd0;
  localparam logic [2:0] s_req       = 3'd1;
  localparam logic [2:0] s_rtrn      = 3'd2;
  localparam logic [2:0] s_done      = 3'd3;
  localparam logic [2:0] s_flush     = 3'd4;
  localparam logic [2:0] s_flush_ack = 3'd5;

  logic [2:0]            state_q;
  dcache_addr_t          addr_q;
  dcache_addr_t          req_addr;
  mem_kind_t             kind_q;
  logic [xlen-1:0]       wdata_q;
  logic [xlen/8-1:0]     be_q;
  logic [line_width-1:0] line_q;
  logic [idx_width-1:0]  flush_cnt_q;
  logic                  flush_go;

  // flush waits until both controllers are quiet
  assign flush_go = flush_i && !ld_busy && !st_busy;
  assign cache_en = enable_i && (state_q != s_flush) && (state_q != s_flush_ack);

  // word aligned, and line aligned for a refill
  always_comb begin
    req_addr            = addr_q;
    req_addr.f.byte_off = '0;
    if (kind_q == mem_refill) begin
      req_addr.f.off = '0;
    end
  end

  assign mem_req_o   = (state_q == s_req);
  assign mem_kind_o  = kind_q;
  assign mem_addr_o  = req_addr.raw;
  assign mem_wdata_o = wdata_q;
  assign mem_be_o    = be_q;
  assign smiss_ack   = mem_req_o && mem_ack_i && (kind_q == mem_write);

  // return to the load, one cycle after the memory return
  assign lmiss_done = (state_q == s_done);
  assign lmiss_word = (kind_q == mem_refill) ? line_q[xlen*addr_q.f.off +: xlen] :
                                               line_q[xlen-1:0];
  assign fill_vld   = (state_q == s_done) && (kind_q == mem_refill);
  assign fill_idx   = addr_q.f.idx;
  assign fill_tag   = addr_q.f.tag;
  assign fill_data  = line_q;

  assign inval_vld   = (state_q == s_flush);
  assign inval_idx   = flush_cnt_q;
  assign flush_ack_o = (state_q == s_flush_ack);

  //////////////////////////////////////////////////
  // sequencer
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q     <= s_idle;
      flush_cnt_q <= '0;
    end else begin
      case (state_q)
        s_idle: begin
          if (flush_go) begin
            state_q <= s_flush;
          end else if (lmiss_req || smiss_req) begin
            state_q <= s_req;
          end
        end
        s_req:  if (mem_ack_i) state_q <= (kind_q == mem_write) ? s_idle : s_rtrn;
        s_rtrn: if (mem_rtrn_vld_i) state_q <= s_done;
        s_done: state_q <= s_idle;
        s_flush: begin
          flush_cnt_q <= flush_cnt_q + 1'b1;
          if (flush_cnt_q == idx_width'(num_lines - 1)) begin
            state_q <= s_flush_ack;
          end
        end
        default: state_q <= s_idle;
      endcase
    end
  end

  // request capture, load ahead of store
  always_ff @(posedge clk_i) begin
    if ((state_q == s_idle) && !flush_go) begin
      if (lmiss_req) begin
        addr_q <= lmiss_addr;
        kind_q <= lmiss_nc ? mem_read_nc : mem_refill;
        be_q   <= '1;
      end else begin
        addr_q <= smiss_addr;
        kind_q <= mem_write;
        be_q   <= smiss_be;
      end
      wdata_q <= smiss_data;
    end
    if ((state_q == s_rtrn) && mem_rtrn_vld_i) begin
      line_q <= mem_rtrn_data_i;
    end
  end

  mem_req_hold : assert property (@(posedge clk_i) disable iff (rst_i)
    (mem_req_o && !mem_ack_i) |=> (mem_req_o && $stable(mem_addr_o)))
    else $error("dcache_miss_unit: memory request dropped or changed before ack");

endmodule

`default_nettype wire

//--- hw/dcache_store_ctrl.sv
//////////////////////////////////////////////////
// dcache store controller
// writes through to memory, then updates the
// cached word if the line is present
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module dcache_store_ctrl
  import dcache_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_i,
  // core store port
  input  logic              st_req_i,
  input  dcache_addr_t      st_addr_i,
  input  logic [xlen-1:0]   st_data_i,
  input  logic [xlen/8-1:0] st_be_i,
  output logic              st_ready_o,
  // miss unit
  output logic              smiss_req,
  output dcache_addr_t      smiss_addr,
  output logic [xlen-1:0]   smiss_data,
  output logic [xlen/8-1:0] smiss_be,
  input  logic              smiss_ack,
  // array update
  output logic              st_wr_req,
  output dcache_addr_t      st_wr_addr,
  output logic [xlen-1:0]   st_wr_data,
  output logic [xlen/8-1:0] st_wr_be,
  input  logic              st_wr_ack
);

  localparam logic [1:0] s_idle = 2'd0;
  localparam logic [1:0] s_mem  = 2'd1;
  localparam logic [1:0] s_upd  = 2'd2;

  logic [1:0]        state_q;
  dcache_addr_t      addr_q;
  logic [xlen-1:0]   data_q;
  logic [xlen/8-1:0] be_q;

  assign st_ready_o = (state_q == s_idle);

  // memory first, so a later refill already holds this store
  assign smiss_req  = (state_q == s_mem);
  assign smiss_addr = addr_q;
  assign smiss_data = data_q;
  assign smiss_be   = be_q;

  assign st_wr_req  = (state_q == s_upd);
  assign st_wr_addr = addr_q;
  assign st_wr_data = data_q;
  assign st_wr_be   = be_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= s_idle;
    end else begin
      case (state_q)
        s_idle:  if (st_req_i) state_q <= s_mem;
        s_mem:   if (smiss_ack) state_q <= s_upd;
        s_upd:   if (st_wr_ack) state_q <= s_idle;
        default: state_q <= s_idle;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (st_ready_o && st_req_i) begin
      addr_q <= st_addr_i;
      data_q <= st_data_i;
      be_q   <= st_be_i;
    end
  end

  st_req_when_ready : assert property (@(posedge clk_i) disable iff (rst_i)
    st_req_i |-> st_ready_o)
    else $error("dcache_store_ctrl: store request while busy");

endmodule

`default_nettype wire

//--- hw/dcache_load_ctrl.sv
//////////////////////////////////////////////////
// dcache load controller
// array lookup, hit return and miss request
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module dcache_load_ctrl
  import dcache_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 cache_en,
  // core load port
  input  logic                 ld_req_i,
  input  dcache_addr_t         ld_addr_i,
  output logic                 ld_ready_o,
  output logic                 ld_valid_o,
  output logic [xlen-1:0]      ld_data_o,
  output logic                 miss_o,
  // array read port
  output logic                 ld_rd_req,
  output logic [idx_width-1:0] ld_rd_idx,
  output logic [off_width-1:0] ld_rd_off,
  input  logic                 ld_rd_ack,
  input  logic [tag_width-1:0] rd_tag,
  input  logic                 rd_valid,
  input  logic [xlen-1:0]      rd_data,
  // miss unit
  output logic                 lmiss_req,
  output logic                 lmiss_nc,
  output dcache_addr_t         lmiss_addr,
  input  logic                 lmiss_done,
  input  logic [xlen-1:0]      lmiss_word
);

  localparam logic [1:0] s_idle    = 2'd0;
  localparam logic [1:0] s_lookup  = 2'd1;
  localparam logic [1:0] s_compare = 2'd2;
  localparam logic [1:0] s_wait    = 2'd3;

  logic [1:0]   state_q;
  logic [1:0]   state_d;
  dcache_addr_t addr_q;
  logic         nc_q;
  logic         hit;

  assign hit = rd_valid && (rd_tag == addr_q.f.tag);

  assign ld_ready_o = (state_q == s_idle);
  // drop the request while the grant is out
  assign ld_rd_req  = (state_q == s_lookup) && !ld_rd_ack;
  assign ld_rd_idx  = addr_q.f.idx;
  assign ld_rd_off  = addr_q.f.off;

  assign ld_valid_o = ((state_q == s_compare) && hit) || ((state_q == s_wait) && lmiss_done);
  assign ld_data_o  = (state_q == s_compare) ? rd_data : lmiss_word;

  assign lmiss_req  = (state_q == s_wait);
  assign lmiss_nc   = nc_q;
  assign lmiss_addr = addr_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      s_idle:    if (ld_req_i) state_d = cache_en ? s_lookup : s_wait;
      s_lookup:  if (ld_rd_ack) state_d = s_compare;
      s_compare: state_d = hit ? s_idle : s_wait;
      s_wait:    if (lmiss_done) state_d = s_idle;
      default:   state_d = s_idle;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= s_idle;
      miss_o  <= 1'b0;
    end else begin
      state_q <= state_d;
      // tag miss, or a load that bypasses the cache
      miss_o  <= ((state_q == s_compare) && !hit) ||
                 ((state_q == s_idle) && ld_req_i && !cache_en);
    end
  end

  always_ff @(posedge clk_i) begin
    if (ld_ready_o && ld_req_i) begin
      addr_q.raw <= ld_addr_i.raw;
      nc_q       <= !cache_en;
    end
  end

  // the miss unit only returns a word to a waiting load
  idle_no_return : assert property (@(posedge clk_i) disable iff (rst_i)
    (state_q == s_idle) |-> !lmiss_done)
    else $error("dcache_load_ctrl: miss return while idle");

endmodule

`default_nettype wire

//--- hw/dcache_mem.sv
//////////////////////////////////////////////////
// dcache arrays
// valid, tag and data storage with a fixed
// priority of refill/invalidate, load, store
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module dcache_mem
  import dcache_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_i,
  // load read port
  input  logic                  ld_rd_req,
  input  logic [idx_width-1:0]  ld_rd_idx,
  input  logic [off_width-1:0]  ld_rd_off,
  output logic                  ld_rd_ack,
  output logic [tag_width-1:0]  rd_tag,
  output logic                  rd_valid,
  output logic [xlen-1:0]       rd_data,
  // store word update
  input  logic                  st_wr_req,
  input  dcache_addr_t          st_wr_addr,
  input  logic [xlen-1:0]       st_wr_data,
  input  logic [xlen/8-1:0]     st_wr_be,
  output logic                  st_wr_ack,
  output logic                  st_wr_hit,
  // refill and invalidate
  input  logic                  fill_vld,
  input  logic [idx_width-1:0]  fill_idx,
  input  logic [tag_width-1:0]  fill_tag,
  input  logic [line_width-1:0] fill_data,
  input  logic                  inval_vld,
  input  logic [idx_width-1:0]  inval_idx
);

  logic [num_lines-1:0] valid_q;
  logic [tag_width-1:0] tag_q  [num_lines];
  logic [xlen-1:0]      data_q [num_lines][line_words];

  logic line_busy;
  logic ld_grant;

  // refill or invalidate owns the arrays this cycle
  assign line_busy = fill_vld | inval_vld;
  assign ld_grant  = ld_rd_req & ~line_busy;

  // store waits behind a pending load and its read cycle
  assign st_wr_ack = st_wr_req & ~line_busy & ~ld_rd_req & ~ld_rd_ack;
  assign st_wr_hit = valid_q[st_wr_addr.f.idx] &
                     (tag_q[st_wr_addr.f.idx] == st_wr_addr.f.tag);

  //////////////////////////////////////////////////
  // control state
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_q   <= '0;
      ld_rd_ack <= 1'b0;
    end else begin
      ld_rd_ack <= ld_grant;
      if (fill_vld) begin
        valid_q[fill_idx] <= 1'b1;
      end else if (inval_vld) begin
        valid_q[inval_idx] <= 1'b0;
      end
    end
  end

  //////////////////////////////////////////////////
  // tag and data arrays
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (fill_vld) begin
      tag_q[fill_idx] <= fill_tag;
      for (int w = 0; w < line_words; w++) begin
        data_q[fill_idx][w] <= fill_data[w*xlen +: xlen];
      end
    end else if (st_wr_ack && st_wr_hit) begin
      // byte merge, only into a line that is present
      for (int b = 0; b < xlen/8; b++) begin
        if (st_wr_be[b]) begin
          data_q[st_wr_addr.f.idx][st_wr_addr.f.off][b*8 +: 8] <= st_wr_data[b*8 +: 8];
        end
      end
    end
  end

  // read result, one cycle after the grant
  always_ff @(posedge clk_i) begin
    if (ld_rd_ack) begin
      rd_tag   <= tag_q[ld_rd_idx];
      rd_valid <= valid_q[ld_rd_idx];
      rd_data  <= data_q[ld_rd_idx][ld_rd_off];
    end
  end

  // miss unit never refills and invalidates at once
  fill_inval_excl : assert property (@(posedge clk_i) disable iff (rst_i)
    !(fill_vld && inval_vld))
    else $error("dcache_mem: fill and invalidate in the same cycle");

endmodule

`default_nettype wire

//--- hw/dcache_pkg.sv
//////////////////////////////////////////////////
// dcache package
// geometry of the direct-mapped L1 data cache,
// its two address views and memory request kinds
//////////////////////////////////////////////////

`default_nettype none

package dcache_pkg;

  // word and address widths
  localparam int unsigned xlen       = 32;
  localparam int unsigned addr_width = 32;

  // line geometry
  localparam int unsigned line_words = 4;
  localparam int unsigned num_lines  = 16;
  localparam int unsigned off_width  = $clog2(line_words);
  localparam int unsigned idx_width  = $clog2(num_lines);
  localparam int unsigned tag_width  = addr_width - idx_width - off_width - 2;
  localparam int unsigned line_width = line_words * xlen;

  // one byte address, seen as the bus address or as cache fields
  typedef union packed {
    logic [addr_width-1:0] raw;
    struct packed {
      logic [tag_width-1:0] tag;
      logic [idx_width-1:0] idx;
      logic [off_width-1:0] off;
      logic [1:0]           byte_off;
    } f;
  } dcache_addr_t;

  // memory request kinds
  typedef enum logic [1:0] {
    mem_refill  = 2'd0,
    mem_read_nc = 2'd1,
    mem_write   = 2'd2
  } mem_kind_t;

endpackage

`default_nettype wire
